/* test/ccu_vectors.txt */
// op_arg_value: 01 write arg=addr, 02 read arg=addr value=expected, 03 tlast, 04 start value=channels
// 05 outputs {locked,error,complete,busy,channels} within arg cycles, 06 error lines, 07 wait, 08 starts
02_18_00000001
01_04_00000040
01_08_00000100
01_0c_00000010
01_10_00000020
01_14_0000000a
02_04_00000040
02_08_00000100
02_0c_00000010
02_10_00000020
02_14_0000000a
01_00_0000001f
04_00_0000000f
05_01_0000001f
03_00_00000000
05_01_0000001f
03_00_00000000
05_01_00000013
03_00_00000000
05_01_000000a0
02_1c_0000000a
02_20_00000003
02_18_00000034
01_00_0000003e
05_04_00000000
02_18_00000021
01_00_0000001b
05_04_000000c0
08_00_00000001
02_18_00000018
01_00_0000005e
05_04_00000000
01_04_00000000
01_00_0000001f
05_04_000000c0
08_00_00000001
01_00_0000005e
05_04_00000000
01_04_00000040
01_00_0000001f
04_00_0000000f
06_00_00000002
05_03_000000cf
07_00_0000000a
06_00_00000000
07_00_00000005
05_00_000000cf
01_00_0000005e
05_04_0000000f
02_18_00000021

/* sources.f */
+incdir+common
common/ccu_reg_pkg.sv
common/ccu_ctrl_pkg.sv
register_file/ccu_register_file.sv
verilog/peripheral_error_sync.sv
control_fsm/ccu_control_fsm.sv
control_fsm/result_batch_tracker.sv
verilog/central_control_unit.sv
test/ccu_props.sv
test/ccu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ccu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* test/ccu_tb.sv */
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_tb;

  localparam int max_lines       = 64;
  localparam int cycles_per_line = 200;

  logic                            fsm_clk;
  logic                            rst;
  ccu_reg_pkg::axil_req_t          axil_req;
  ccu_reg_pkg::axil_rsp_t          axil_rsp;
  logic [`CCU_NUM_PERIPHERALS-1:0] peripheral_error;
  logic                            rslt_tlast;
  logic                            operation_start;
  logic [31:0]                     data_size;
  logic [31:0]                     grid_size;
  logic [31:0]                     scle_size;
  logic [31:0]                     pckt_size;
  logic [`CCU_RSLT_CHANNELS-1:0]   use_channels;
  logic                            operation_busy;
  logic                            operation_complete;
  logic                            operation_error;
  logic                            locked;

  // Vector word is op, argument, value
  logic [47:0]                   vectors [0:max_lines-1];
  logic [31:0]                   size_shadow [0:15];
  logic [31:0]                   lfsr;
  logic [7:0]                    op;
  logic [7:0]                    arg;
  logic [31:0]                   value;
  logic [31:0]                   rd;
  logic [127:0]                  start_sizes;
  logic [`CCU_RSLT_CHANNELS-1:0] start_channels;
  string                         name;
  int                            n_lines;
  int                            watchdog_cycles;
  int unsigned                   cycle = 0;
  int unsigned                   start_hs_cycle;
  int unsigned                   start_seen_cycle;
  int unsigned                   start_count;
  int unsigned                   starts_checked;

  central_control_unit dut (
    .fsm_clk            (fsm_clk),
    .rst                (rst),
    .axil_req           (axil_req),
    .axil_rsp           (axil_rsp),
    .peripheral_error   (peripheral_error),
    .rslt_tlast         (rslt_tlast),
    .operation_start    (operation_start),
    .data_size          (data_size),
    .grid_size          (grid_size),
    .scle_size          (scle_size),
    .pckt_size          (pckt_size),
    .use_channels       (use_channels),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .locked             (locked)
  );

  initial begin
    fsm_clk = 1'b0;
    forever #4 fsm_clk = ~fsm_clk;
  end

  always @(posedge fsm_clk) begin
    cycle <= cycle + 1;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                         test, expected, actual));
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return bits;
  endfunction

  function automatic logic [31:0] output_word();
    return 32'({locked, operation_error, operation_complete, operation_busy, use_channels});
  endfunction

  // Catches each start pulse, sizes must be zero outside it
  always @(posedge fsm_clk) begin
    if (!rst && operation_start) begin
      start_count      <= start_count + 1;
      start_seen_cycle <= cycle;
      start_sizes      <= {data_size, grid_size, scle_size, pckt_size};
      start_channels   <= use_channels;
    end else if (!rst) begin
      compare_value("sizes outside start", 32'd0,
                    data_size | grid_size | scle_size | pckt_size);
    end
  end

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] delay;
    @(posedge fsm_clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wvalid  <= 1'b1;
    @(posedge fsm_clk);
    while (!(axil_rsp.awready && axil_rsp.wready)) @(posedge fsm_clk);
    if (addr == 8'h00 && data[0]) begin
      start_hs_cycle = cycle;
    end
    size_shadow[addr[5:2]] = data;
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(posedge fsm_clk);
    while (!axil_rsp.bvalid) @(posedge fsm_clk);
    delay = take_bits(2);
    repeat (delay) begin
      @(posedge fsm_clk);
      compare_value("bvalid held under back-pressure", 32'd1, 32'(axil_rsp.bvalid));
    end
    axil_req.bready <= 1'b1;
    @(posedge fsm_clk);
    compare_value("bvalid at handshake", 32'd1, 32'(axil_rsp.bvalid));
    axil_req.bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    logic [31:0] delay;
    @(posedge fsm_clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    @(posedge fsm_clk);
    while (!axil_rsp.arready) @(posedge fsm_clk);
    axil_req.arvalid <= 1'b0;
    @(posedge fsm_clk);
    while (!axil_rsp.rvalid) @(posedge fsm_clk);
    delay = take_bits(2);
    repeat (delay) begin
      @(posedge fsm_clk);
      compare_value("rvalid held under back-pressure", 32'd1, 32'(axil_rsp.rvalid));
    end
    axil_req.rready <= 1'b1;
    @(posedge fsm_clk);
    compare_value("rvalid at handshake", 32'd1, 32'(axil_rsp.rvalid));
    data = axil_rsp.rdata;
    axil_req.rready <= 1'b0;
  endtask

  task automatic pulse_tlast();
    @(posedge fsm_clk);
    rslt_tlast <= 1'b1;
    @(posedge fsm_clk);
    rslt_tlast <= 1'b0;
  endtask

  task automatic drive_error(input logic [31:0] mask);
    @(posedge fsm_clk);
    peripheral_error <= mask[`CCU_NUM_PERIPHERALS-1:0];
    @(posedge fsm_clk);
  endtask

  // Outputs must reach the expected word within the limit
  task automatic await_outputs(input string test, input int limit, input logic [31:0] expected);
    logic [31:0] observed;
    int          tries;
    observed = '0;
    tries    = (limit == 0) ? 1 : limit;
    for (int i = 0; i < tries; i++) begin
      @(negedge fsm_clk);
      observed = output_word();
      if (observed == expected) break;
    end
    compare_value(test, expected, observed);
  endtask

  task automatic check_start(input string test, input logic [31:0] channels);
    int waited;
    waited = 0;
    while (start_count == starts_checked && waited < 20) begin
      @(posedge fsm_clk);
      waited++;
    end
    if (start_count == starts_checked) begin
      fail_run($sformatf("%s: no operation_start pulse after the start write", test));
    end else begin
      starts_checked++;
      compare_value({test, " start count"}, starts_checked, start_count);
      compare_value({test, " start latency"}, 32'd3, start_seen_cycle - start_hs_cycle);
      compare_value({test, " data_size"}, size_shadow[1], start_sizes[127:96]);
      compare_value({test, " grid_size"}, size_shadow[2], start_sizes[95:64]);
      compare_value({test, " scle_size"}, size_shadow[3], start_sizes[63:32]);
      compare_value({test, " pckt_size"}, size_shadow[4], start_sizes[31:0]);
      compare_value({test, " use_channels"}, channels, 32'(start_channels));
    end
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge fsm_clk);
    fail_run("Watchdog expired before the vector replay finished");
  end

  initial begin
    rst              = 1'b1;
    axil_req         = '0;
    peripheral_error = '0;
    rslt_tlast       = 1'b0;
    lfsr             = 32'd96813;
    start_count      = 0;
    starts_checked   = 0;
    start_hs_cycle   = 0;
    for (int i = 0; i < 16; i++) begin
      size_shadow[i] = '0;
    end
    // Unused entries read as the end marker
    for (int i = 0; i < max_lines; i++) begin
      vectors[i] = '1;
    end
    $readmemh("test/ccu_vectors.txt", vectors);
    n_lines = 0;
    while (n_lines < max_lines && vectors[n_lines][47:40] != 8'hff) n_lines++;
    if (n_lines == 0) begin
      fail_run("The vector file holds no operations");
    end
    watchdog_cycles = n_lines * cycles_per_line + 10;

    repeat (10) @(posedge fsm_clk);
    rst <= 1'b0;

    for (int idx = 0; idx < n_lines; idx++) begin
      op    = vectors[idx][47:40];
      arg   = vectors[idx][39:32];
      value = vectors[idx][31:0];
      name  = $sformatf("vector %0d op %02h", idx + 1, op);
      case (op)
        8'h01: bus_write(arg, value);
        8'h02: begin
          bus_read(arg, rd);
          compare_value(name, value, rd);
        end
        8'h03: pulse_tlast();
        8'h04: check_start(name, value);
        8'h05: await_outputs(name, int'(arg), value);
        8'h06: drive_error(value);
        8'h07: repeat (value) @(posedge fsm_clk);
        8'h08: compare_value(name, value, start_count);
        default: fail_run($sformatf("%s: unknown operation in the vector file", name));
      endcase
    end

    repeat (5) @(posedge fsm_clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* test/ccu_props.sv */
`timescale 1ns/1ps

module ccu_props (
  input logic fsm_clk,
  input logic rst,
  input logic done_ack,
  input logic abort_req,
  input logic operation_start,
  input logic operation_complete,
  input logic operation_error,
  input logic locked
);

  // A run starts with a single-cycle pulse
  start_one_cycle: assert property (@(posedge fsm_clk) disable iff (rst)
    operation_start |=> !operation_start)
    else $error("operation_start stayed high for more than one cycle");

  complete_error_exclusive: assert property (@(posedge fsm_clk) disable iff (rst)
    !(operation_complete && operation_error))
    else $error("operation_complete and operation_error high together");

  // Lock is released only by an acknowledge or an abort
  locked_until_release: assert property (@(posedge fsm_clk) disable iff (rst)
    (locked && !done_ack && !abort_req) |=> locked)
    else $error("locked dropped without an acknowledge or abort");

endmodule

bind ccu_control_fsm ccu_props u_props (
  .fsm_clk            (fsm_clk),
  .rst                (rst),
  .done_ack           (done_ack),
  .abort_req          (abort_req),
  .operation_start    (operation_start),
  .operation_complete (operation_complete),
  .operation_error    (operation_error),
  .locked             (locked)
);

/* verilog/central_control_unit.sv */
`timescale 1ns/1ps
`include "ccu_params.svh"

module central_control_unit (
  input  logic                            fsm_clk,
  input  logic                            rst,
  input  ccu_reg_pkg::axil_req_t          axil_req,
  output ccu_reg_pkg::axil_rsp_t          axil_rsp,
  input  logic [`CCU_NUM_PERIPHERALS-1:0] peripheral_error,
  input  logic                            rslt_tlast,
  output logic                            operation_start,
  output logic [31:0]                     data_size,
  output logic [31:0]                     grid_size,
  output logic [31:0]                     scle_size,
  output logic [31:0]                     pckt_size,
  output logic [`CCU_RSLT_CHANNELS-1:0]   use_channels,
  output logic                            operation_busy,
  output logic                            operation_complete,
  output logic                            operation_error,
  output logic                            locked
);

  ccu_ctrl_pkg::run_cfg_t     cfg;
  ccu_reg_pkg::status_bits_t  status;
  logic                       start_req;
  logic                       done_ack;
  logic                       abort_req;
  logic                       internal_error;
  logic                       load_batch;
  logic                       last_batch;
  logic [31:0]                results_exported;
  logic [31:0]                iterations;

  ccu_register_file u_register_file (
    .fsm_clk          (fsm_clk),
    .rst              (rst),
    .axil_req         (axil_req),
    .axil_rsp         (axil_rsp),
    .cfg              (cfg),
    .start_req        (start_req),
    .done_ack         (done_ack),
    .abort_req        (abort_req),
    .status           (status),
    .results_exported (results_exported),
    .iterations       (iterations)
  );

  // Peripheral errors arrive from other clock domains
  peripheral_error_sync u_error_sync (
    .fsm_clk          (fsm_clk),
    .rst              (rst),
    .peripheral_error (peripheral_error),
    .internal_error   (internal_error)
  );

  ccu_control_fsm u_control_fsm (
    .fsm_clk            (fsm_clk),
    .rst                (rst),
    .cfg                (cfg),
    .start_req          (start_req),
    .done_ack           (done_ack),
    .abort_req          (abort_req),
    .internal_error     (internal_error),
    .last_batch         (last_batch),
    .rslt_tlast         (rslt_tlast),
    .load_batch         (load_batch),
    .status             (status),
    .operation_start    (operation_start),
    .data_size          (data_size),
    .grid_size          (grid_size),
    .scle_size          (scle_size),
    .pckt_size          (pckt_size),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .locked             (locked)
  );

  result_batch_tracker u_batch_tracker (
    .fsm_clk          (fsm_clk),
    .rst              (rst),
    .rslt_size        (cfg.rslt_size),
    .load_batch       (load_batch),
    .rslt_tlast       (rslt_tlast),
    .last_batch       (last_batch),
    .use_channels     (use_channels),
    .results_exported (results_exported),
    .iterations       (iterations)
  );

endmodule

/* control_fsm/result_batch_tracker.sv */
`timescale 1ns/1ps
`include "ccu_params.svh"

module result_batch_tracker (
  input  logic                          fsm_clk,
  input  logic                          rst,
  input  logic [31:0]                   rslt_size,
  input  logic                          load_batch,
  input  logic                          rslt_tlast,
  output logic                          last_batch,
  output logic [`CCU_RSLT_CHANNELS-1:0] use_channels,
  output logic [31:0]                   results_exported,
  output logic [31:0]                   iterations
);

  localparam logic [31:0] channels = 32'(`CCU_RSLT_CHANNELS);

  logic [31:0]                   remaining;
  logic [31:0]                   source;
  logic [31:0]                   batch;
  logic [`CCU_RSLT_CHANNELS-1:0] channels_next;

  // A new run counts from the programmed size, later batches from what is left
  assign source     = load_batch ? rslt_size : remaining;
  assign batch      = (source > channels) ? channels : source;
  assign last_batch = (remaining == 32'd0);

  // Lowest batch bits select the active channels
  always_comb begin
    for (int i = 0; i < `CCU_RSLT_CHANNELS; i++) begin
      channels_next[i] = (32'(i) < batch);
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      remaining        <= '0;
      results_exported <= '0;
      iterations       <= '0;
      use_channels     <= '0;
    end else if (load_batch) begin
      remaining        <= rslt_size - batch;
      results_exported <= batch;
      iterations       <= '0;
      use_channels     <= channels_next;
    end else if (rslt_tlast) begin
      remaining        <= remaining - batch;
      results_exported <= results_exported + batch;
      iterations       <= iterations + 32'd1;
      use_channels     <= channels_next;
    end
  end

endmodule

/* control_fsm/ccu_control_fsm.sv */
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_control_fsm (
  input  logic                       fsm_clk,
  input  logic                       rst,
  input  ccu_ctrl_pkg::run_cfg_t     cfg,
  input  logic                       start_req,
  input  logic                       done_ack,
  input  logic                       abort_req,
  input  logic                       internal_error,
  input  logic                       last_batch,
  input  logic                       rslt_tlast,
  output logic                       load_batch,
  output ccu_reg_pkg::status_bits_t  status,
  output logic                       operation_start,
  output logic [31:0]                data_size,
  output logic [31:0]                grid_size,
  output logic [31:0]                scle_size,
  output logic [31:0]                pckt_size,
  output logic                       operation_busy,
  output logic                       operation_complete,
  output logic                       operation_error,
  output logic                       locked
);

  localparam logic [31:0] max_size = 32'd1 << `CCU_SIZE_WIDTH;

  ccu_ctrl_pkg::ccu_state_t state;
  ccu_ctrl_pkg::ccu_state_t state_next;
  logic                     cfg_valid;
  logic                     enter_run;

  function automatic logic size_ok(input logic [31:0] size);
    size_ok = (size != 32'd0) && (size <= max_size);
  endfunction

  assign cfg_valid = cfg.data_loaded && cfg.grid_loaded && cfg.scle_loaded &&
                     cfg.wght_loaded && size_ok(cfg.data_size) &&
                     size_ok(cfg.grid_size) && size_ok(cfg.scle_size) &&
                     size_ok(cfg.pckt_size) && size_ok(cfg.rslt_size);

  // Tracker loads the result count and first batch while in start
  assign load_batch = (state == ccu_ctrl_pkg::st_start);
  assign enter_run  = load_batch && (state_next == ccu_ctrl_pkg::st_operate);

  always_comb begin
    state_next = state;
    case (state)
      ccu_ctrl_pkg::st_idle: begin
        if (start_req) begin
          state_next = cfg_valid ? ccu_ctrl_pkg::st_start : ccu_ctrl_pkg::st_error;
        end
      end
      ccu_ctrl_pkg::st_start:   state_next = ccu_ctrl_pkg::st_operate;
      ccu_ctrl_pkg::st_operate: begin
        if (rslt_tlast && last_batch) begin
          state_next = ccu_ctrl_pkg::st_done;
        end
      end
      // Stay locked on the result until the processor acknowledges
      ccu_ctrl_pkg::st_done: begin
        if (done_ack) begin
          state_next = ccu_ctrl_pkg::st_idle;
        end
      end
      ccu_ctrl_pkg::st_error: state_next = ccu_ctrl_pkg::st_error;
      ccu_ctrl_pkg::st_abort: state_next = ccu_ctrl_pkg::st_idle;
      default:                state_next = ccu_ctrl_pkg::st_idle;
    endcase
    if (internal_error) begin
      state_next = ccu_ctrl_pkg::st_error;
    end
    // Abort overrides everything
    if (abort_req) begin
      state_next = ccu_ctrl_pkg::st_abort;
    end
  end

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      state              <= ccu_ctrl_pkg::st_idle;
      operation_start    <= 1'b0;
      data_size          <= '0;
      grid_size          <= '0;
      scle_size          <= '0;
      pckt_size          <= '0;
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
      locked             <= 1'b0;
    end else begin
      state           <= state_next;
      operation_start <= enter_run;
      // Sizes are only valid alongside the start pulse
      data_size       <= enter_run ? cfg.data_size : 32'd0;
      grid_size       <= enter_run ? cfg.grid_size : 32'd0;
      scle_size       <= enter_run ? cfg.scle_size : 32'd0;
      pckt_size       <= enter_run ? cfg.pckt_size : 32'd0;
      operation_busy  <= (state_next == ccu_ctrl_pkg::st_start) ||
                         (state_next == ccu_ctrl_pkg::st_operate);
      operation_complete <= (state_next == ccu_ctrl_pkg::st_done);
      operation_error    <= (state_next == ccu_ctrl_pkg::st_error);
      locked             <= (state_next == ccu_ctrl_pkg::st_done) ||
                            (state_next == ccu_ctrl_pkg::st_error);
    end
  end

  always_comb begin
    status          = '0;
    status.idle     = (state == ccu_ctrl_pkg::st_idle);
    status.busy     = operation_busy;
    status.complete = operation_complete;
    status.error    = operation_error;
    status.locked   = locked;
    status.valid    = cfg_valid;
  end

endmodule

/* verilog/peripheral_error_sync.sv */
`timescale 1ns/1ps
`include "ccu_params.svh"

module peripheral_error_sync (
  input  logic                            fsm_clk,
  input  logic                            rst,
  input  logic [`CCU_NUM_PERIPHERALS-1:0] peripheral_error,
  output logic                            internal_error
);

  logic [`CCU_NUM_PERIPHERALS-1:0] meta;
  logic [`CCU_NUM_PERIPHERALS-1:0] synced;

  // Two flops per line before any logic sees the error
  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      meta   <= '0;
      synced <= '0;
    end else begin
      meta   <= peripheral_error;
      synced <= meta;
    end
  end

  // Any peripheral in error stops the core
  assign internal_error = |synced;

endmodule

/* register_file/ccu_register_file.sv */
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_register_file (
  input  logic                      fsm_clk,
  input  logic                      rst,
  input  ccu_reg_pkg::axil_req_t    axil_req,
  output ccu_reg_pkg::axil_rsp_t    axil_rsp,
  output ccu_ctrl_pkg::run_cfg_t    cfg,
  output logic                      start_req,
  output logic                      done_ack,
  output logic                      abort_req,
  input  ccu_reg_pkg::status_bits_t status,
  input  logic [31:0]               results_exported,
  input  logic [31:0]               iterations
);

  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_ctrl;
  logic                   bvalid;
  logic                   rvalid;
  logic [31:0]            rdata;
  ccu_reg_pkg::reg_word_u wr_word;
  ccu_reg_pkg::reg_word_u rd_word;

  // Address and data are taken together, a pending response stalls new writes
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_fire = axil_req.arvalid && !rvalid;
  assign wr_ctrl = (axil_req.awaddr == ccu_reg_pkg::addr_ctrl);
  assign wr_word = axil_req.wdata;

  assign axil_rsp.awready = wr_fire;
  assign axil_rsp.wready  = wr_fire;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.arready = rd_fire;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rvalid  = rvalid;

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      cfg       <= '0;
      bvalid    <= 1'b0;
      start_req <= 1'b0;
      done_ack  <= 1'b0;
      abort_req <= 1'b0;
    end else begin
      // Command bits only pulse, they are never stored
      start_req <= wr_fire && wr_ctrl && wr_word.ctrl.start;
      done_ack  <= wr_fire && wr_ctrl && wr_word.ctrl.done_ack;
      abort_req <= wr_fire && wr_ctrl && wr_word.ctrl.abort;

      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end

      if (wr_fire) begin
        case (axil_req.awaddr)
          ccu_reg_pkg::addr_ctrl: begin
            cfg.data_loaded <= wr_word.ctrl.data_loaded;
            cfg.grid_loaded <= wr_word.ctrl.grid_loaded;
            cfg.scle_loaded <= wr_word.ctrl.scle_loaded;
            cfg.wght_loaded <= wr_word.ctrl.wght_loaded;
          end
          ccu_reg_pkg::addr_data_size: cfg.data_size <= wr_word.raw;
          ccu_reg_pkg::addr_grid_size: cfg.grid_size <= wr_word.raw;
          ccu_reg_pkg::addr_scle_size: cfg.scle_size <= wr_word.raw;
          ccu_reg_pkg::addr_pckt_size: cfg.pckt_size <= wr_word.raw;
          ccu_reg_pkg::addr_rslt_size: cfg.rslt_size <= wr_word.raw;
          default: begin
          end
        endcase
      end
    end
  end

  // Read multiplexer, unmapped addresses return zero
  always_comb begin
    rd_word = '0;
    case (axil_req.araddr)
      ccu_reg_pkg::addr_ctrl: begin
        rd_word.ctrl.data_loaded = cfg.data_loaded;
        rd_word.ctrl.grid_loaded = cfg.grid_loaded;
        rd_word.ctrl.scle_loaded = cfg.scle_loaded;
        rd_word.ctrl.wght_loaded = cfg.wght_loaded;
      end
      ccu_reg_pkg::addr_data_size: rd_word.raw    = cfg.data_size;
      ccu_reg_pkg::addr_grid_size: rd_word.raw    = cfg.grid_size;
      ccu_reg_pkg::addr_scle_size: rd_word.raw    = cfg.scle_size;
      ccu_reg_pkg::addr_pckt_size: rd_word.raw    = cfg.pckt_size;
      ccu_reg_pkg::addr_rslt_size: rd_word.raw    = cfg.rslt_size;
      ccu_reg_pkg::addr_status:    rd_word.status = status;
      ccu_reg_pkg::addr_prog_rslt: rd_word.raw    = results_exported;
      ccu_reg_pkg::addr_prog_iter: rd_word.raw    = iterations;
      default:                     rd_word.raw    = '0;
    endcase
  end

  always_ff @(posedge fsm_clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  // Read data is captured with the address handshake
  always_ff @(posedge fsm_clk) begin
    if (rd_fire) begin
      rdata <= rd_word.raw;
    end
  end

endmodule

/* common/ccu_ctrl_pkg.sv */
package ccu_ctrl_pkg;

  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_start   = 3'd1,
    st_operate = 3'd2,
    st_done    = 3'd3,
    st_error   = 3'd4,
    st_abort   = 3'd5
  } ccu_state_t;

  // Run configuration as held by the register file
  typedef struct packed {
    logic [31:0] data_size;
    logic [31:0] grid_size;
    logic [31:0] scle_size;
    logic [31:0] pckt_size;
    logic [31:0] rslt_size;
    logic        data_loaded;
    logic        grid_loaded;
    logic        scle_loaded;
    logic        wght_loaded;
  } run_cfg_t;

endpackage

/* common/ccu_reg_pkg.sv */
`include "ccu_params.svh"

package ccu_reg_pkg;

  // Register map, one 32-bit word per address
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_ctrl      = 'h00;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_data_size = 'h04;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_grid_size = 'h08;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_scle_size = 'h0c;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_pckt_size = 'h10;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_rslt_size = 'h14;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_status    = 'h18;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_prog_rslt = 'h1c;
  localparam logic [`CCU_ADDR_WIDTH-1:0] addr_prog_iter = 'h20;

  // AXI-Lite master to slave
  typedef struct packed {
    logic [`CCU_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    logic [31:0]                wdata;
    logic                       wvalid;
    logic                       bready;
    logic [`CCU_ADDR_WIDTH-1:0] araddr;
    logic                       arvalid;
    logic                       rready;
  } axil_req_t;

  // AXI-Lite slave to master, responses are always OKAY
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
  } axil_rsp_t;

  // Control word, bit 0 is start
  typedef struct packed {
    logic [24:0] reserved;
    logic        abort;
    logic        done_ack;
    logic        wght_loaded;
    logic        scle_loaded;
    logic        grid_loaded;
    logic        data_loaded;
    logic        start;
  } ctrl_bits_t;

  // Status word, bit 0 is idle
  typedef struct packed {
    logic [25:0] reserved;
    logic        valid;
    logic        locked;
    logic        error;
    logic        complete;
    logic        busy;
    logic        idle;
  } status_bits_t;

  // One bus word seen as raw data or as flags
  typedef union packed {
    logic [31:0]  raw;
    ctrl_bits_t   ctrl;
    status_bits_t status;
  } reg_word_u;

endpackage

/* common/ccu_params.svh */
`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// Register byte address width
`define CCU_ADDR_WIDTH 8

// Result channels served per batch
`define CCU_RSLT_CHANNELS 4

// Peripheral error lines entering from other clock domains
`define CCU_NUM_PERIPHERALS 3

// Largest legal size is 2 to the power of this width
`define CCU_SIZE_WIDTH 16

`endif
